//--- list.f
+incdir+design/seg_disp
common/io_pkg.sv
design/ps2_kbd/scan_fifo.sv
design/ps2_kbd/ps2_kbd.sv
design/seg_disp/seg_disp.sv
design/io_top.sv
bench/io_assertions.sv
bench/io_tb.sv

//--- run.sh
#!/bin/sh
# build the io_tb simulation with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module io_tb -f list.f -o io_tb_sim
./obj_dir/io_tb_sim

//--- bench/io_tb.sv
// top-level testbench for io_top that drives PS/2 frames and host strobes and checks codes and frames
module io_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // ps2 half period in clk200m cycles
    localparam int half_bit   = 40;
    localparam int wait_limit = 4000;

    logic                         clk200m = 1'b0;
    logic                         rst_n;
    logic                         ps2_clk;
    logic                         ps2_data;
    logic                         key_rd;
    logic                         disp_we;
    logic [io_pkg::seg_width-1:0] disp_wdata;
    io_pkg::scan_t                key_data;
    logic                         key_ready;
    logic                         key_overflow;
    logic                         key_parity_err;
    logic                         seg_clk;
    logic                         seg_clrn;
    logic                         seg_sout;
    logic                         seg_en;

    logic [31:0]   rng = 32'hcf80_df54;
    logic [63:0]   exp_frames[$];
    io_pkg::scan_t burst[6];
    io_pkg::scan_t code;

    io_top #(
        .FIFO_DEPTH    (4),
        .FRAME_TIMEOUT (300),
        .SEG_DIV_LOG2  (2)
    ) u_dut (.*);

    initial begin
        forever #5 clk200m = ~clk200m;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // data plus parity bit hold an odd count of ones
    function automatic logic odd_parity(input io_pkg::scan_t d);
        return ~(^d);
    endfunction

    // lit segments listed as g..a and inverted for the active-low pins
    function automatic io_pkg::seg_byte_t font_ref(input logic [3:0] h);
        logic [6:0] lit;
        case (h)
            4'h0: lit = 7'b0111111;
            4'h1: lit = 7'b0000110;
            4'h2: lit = 7'b1011011;
            4'h3: lit = 7'b1001111;
            4'h4: lit = 7'b1100110;
            4'h5: lit = 7'b1101101;
            4'h6: lit = 7'b1111101;
            4'h7: lit = 7'b0000111;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1101111;
            4'ha: lit = 7'b1110111;
            4'hb: lit = 7'b1111100;
            4'hc: lit = 7'b0111001;
            4'hd: lit = 7'b1011110;
            4'he: lit = 7'b1111001;
            4'hf: lit = 7'b1110001;
        endcase
        // decimal point dark
        return {1'b1, ~lit};
    endfunction

    // digit 7 in the top byte goes first on the wire
    function automatic logic [63:0] frame_ref(input logic [31:0] v);
        logic [63:0] f;
        for (int d = 0; d < io_pkg::seg_digits; d++) begin
            f[d*8 +: 8] = font_ref(v[d*4 +: 4]);
        end
        return f;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_fail(input string test, input logic [63:0] expected,
                              input logic [63:0] actual);
        stop_run($sformatf("CHECK FAILED %s expected %h actual %h", test, expected, actual));
    endtask

    task automatic wait_key_ready();
        int n = 0;
        while (!key_ready) begin
            if (n == wait_limit) stop_run("timeout waiting for key_ready");
            n++;
            @(negedge clk200m);
        end
    endtask

    task automatic wait_seg_en(input logic level);
        int n = 0;
        while (seg_en !== level) begin
            if (n == wait_limit) stop_run("timeout waiting for seg_en");
            n++;
            @(negedge clk200m);
        end
    endtask

    task automatic wait_frames_done();
        int n = 0;
        while (exp_frames.size() != 0) begin
            if (n == wait_limit) stop_run("timeout waiting for a display frame");
            n++;
            @(negedge clk200m);
        end
    endtask

    // one ps2 frame as the device sends it
    // nbits below 11 cuts it short
    task automatic send_frame(input io_pkg::scan_t d, input logic bad_par, input int nbits);
        logic [10:0] f;
        f = {1'b1, odd_parity(d) ^ bad_par, d, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            ps2_data = f[i];
            repeat (half_bit) @(negedge clk200m);
            ps2_clk = 1'b0;
            repeat (half_bit) @(negedge clk200m);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (half_bit) @(negedge clk200m);
    endtask

    task automatic pop_check(input string test, input io_pkg::scan_t expected);
        wait_key_ready();
        assert (key_data == expected) else check_fail(test, 64'(expected), 64'(key_data));
        key_rd = 1'b1;
        @(negedge clk200m);
        key_rd = 1'b0;
    endtask

    task automatic write_disp(input logic [31:0] v, input logic shown);
        if (shown) exp_frames.push_back(frame_ref(v));
        disp_wdata = v;
        disp_we    = 1'b1;
        @(negedge clk200m);
        disp_we    = 1'b0;
    endtask

    // serial receiver catching seg_clk rises from the system clock
    initial begin
        logic        clk_q;
        logic [63:0] got;
        int          got_bits;
        clk_q    = 1'b0;
        got      = '0;
        got_bits = 0;
        forever begin
            @(posedge clk200m);
            if (seg_en && seg_clk && !clk_q) begin
                got = {got[62:0], seg_sout};
                got_bits++;
            end
            clk_q = seg_clk;
            if (got_bits == 64) begin
                assert (exp_frames.size() != 0) else stop_run("display sent an unexpected frame");
                assert (got == exp_frames[0]) else check_fail("display frame", exp_frames[0], got);
                void'(exp_frames.pop_front());
                got_bits = 0;
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        key_rd     = 1'b0;
        disp_we    = 1'b0;
        disp_wdata = '0;
        // reset value shows up once as eight zeros
        exp_frames.push_back(frame_ref(32'h0));
        repeat (10) @(negedge clk200m);
        assert (!seg_clrn && !seg_en && !seg_clk && !seg_sout)
            else stop_run("display outputs wrong during reset");
        rst_n = 1'b1;
        @(negedge clk200m);
        assert (seg_clrn) else stop_run("seg_clrn stayed low after reset");
        assert (!key_ready && !key_overflow && !key_parity_err)
            else stop_run("keyboard flags not clear after reset");

        // random codes with one pop each
        for (int i = 0; i < 20; i++) begin
            rng  = xorshift32(rng);
            code = rng[7:0];
            send_frame(code, 1'b0, 11);
            pop_check("single code", code);
            assert (!key_ready) else check_fail("ready after pop", 64'd0, 64'(key_ready));
        end
        assert (!key_parity_err)
            else check_fail("parity flag on good frames", 64'd0, 64'(key_parity_err));

        // even parity gets dropped and flagged
        // the next good frame still lands
        send_frame(8'h5a, 1'b1, 11);
        assert (!key_ready && key_parity_err) else stop_run("bad parity frame not dropped");
        send_frame(8'h3c, 1'b0, 11);
        pop_check("after parity error", 8'h3c);

        // six codes into a four-deep queue lose the last two
        for (int i = 0; i < 6; i++) begin
            rng      = xorshift32(rng);
            burst[i] = rng[15:8];
            send_frame(burst[i], 1'b0, 11);
            if (i == 3) begin
                // queue full now but no push has met it yet
                assert (!key_overflow)
                    else check_fail("overflow before full", 64'd0, 64'(key_overflow));
            end
        end
        assert (key_overflow) else check_fail("overflow flag", 64'd1, 64'(key_overflow));
        for (int i = 0; i < 4; i++) begin
            pop_check("overflow order", burst[i]);
        end
        assert (!key_ready) else stop_run("codes beyond the queue depth came out");

        // truncated frame and a stall past the watchdog before a good one
        send_frame(8'ha7, 1'b0, 5);
        repeat (400) @(negedge clk200m);
        assert (!key_ready) else stop_run("truncated frame reached the queue");
        send_frame(8'h29, 1'b0, 11);
        pop_check("after stall", 8'h29);
        assert (!key_ready) else stop_run("stray code after the stalled frame");

        // one write per idle gap
        for (int i = 0; i < 4; i++) begin
            wait_frames_done();
            wait_seg_en(1'b0);
            rng = xorshift32(rng);
            write_disp(rng, 1'b1);
        end

        // of three writes inside a running frame only the last shows next
        wait_frames_done();
        wait_seg_en(1'b0);
        rng = xorshift32(rng);
        write_disp(rng, 1'b1);
        wait_seg_en(1'b1);
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            write_disp(rng, i == 2);
            repeat (5) @(negedge clk200m);
        end
        wait_frames_done();
        wait_seg_en(1'b0);
        repeat (32) @(negedge clk200m);
        assert (!seg_en) else stop_run("display started a frame without a write");

        $display("All tests passed");
        $finish;
    end

endmodule

//--- bench/io_assertions.sv
// protocol assertions for io_top, attached to every io_top instance by the bind below
module io_assertions (
    input logic          clk200m,
    input logic          rst_n,
    input logic          seg_clk,
    input logic          seg_en,
    input logic          key_rd,
    input logic          key_ready,
    input logic          key_overflow,
    input logic          key_parity_err,
    input io_pkg::scan_t key_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // no clock pulses between frames
    a_seg_clk_idle: assert property (@(posedge clk200m) disable iff (!rst_n)
        !seg_en |-> !seg_clk) else $error("seg_clk high outside a frame");

    // sticky flags
    a_overflow_sticky: assert property (@(posedge clk200m) disable iff (!rst_n)
        !$fell(key_overflow)) else $error("key_overflow fell without reset");
    a_parity_sticky: assert property (@(posedge clk200m) disable iff (!rst_n)
        !$fell(key_parity_err)) else $error("key_parity_err fell without reset");

    // head of queue holds until popped
    a_head_stable: assert property (@(posedge clk200m) disable iff (!rst_n)
        key_ready && !key_rd |=> $stable(key_data)) else $error("key_data moved without a pop");

endmodule

bind io_top io_assertions u_io_assertions (.*);

//--- design/io_top.sv
// peripheral top level: PS/2 keyboard receiver and serial display driver behind host strobes
module io_top #(
    parameter int FIFO_DEPTH    = 16,
    parameter int FRAME_TIMEOUT = 20000,
    parameter int SEG_DIV_LOG2  = 10
) (
    input  logic                         clk200m,
    input  logic                         rst_n,

    // keyboard lines and host read side
    input  logic                         ps2_clk,
    input  logic                         ps2_data,
    input  logic                         key_rd,
    output io_pkg::scan_t                key_data,
    output logic                         key_ready,
    output logic                         key_overflow,
    output logic                         key_parity_err,

    // display host write side and board pins
    input  logic                         disp_we,
    input  logic [io_pkg::seg_width-1:0] disp_wdata,
    output logic                         seg_clk,
    output logic                         seg_clrn,
    output logic                         seg_sout,
    output logic                         seg_en
);

    // keyboard receiver with its scan-code queue
    ps2_kbd #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .FRAME_TIMEOUT (FRAME_TIMEOUT)
    ) u_ps2_kbd (
        .clk200m        (clk200m),
        .rst_n          (rst_n),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .key_rd         (key_rd),
        .key_data       (key_data),
        .key_ready      (key_ready),
        .key_overflow   (key_overflow),
        .key_parity_err (key_parity_err)
    );

    // eight-digit serial display
    seg_disp #(
        .SEG_DIV_LOG2 (SEG_DIV_LOG2)
    ) u_seg_disp (
        .clk200m    (clk200m),
        .rst_n      (rst_n),
        .disp_we    (disp_we),
        .disp_wdata (disp_wdata),
        .seg_clk    (seg_clk),
        .seg_clrn   (seg_clrn),
        .seg_sout   (seg_sout),
        .seg_en     (seg_en)
    );

endmodule

//--- design/seg_disp/seg_disp.sv
// serial seven-segment driver: latches a 32-bit value and shifts eight segment bytes to the board
module seg_disp #(
    // one serial bit lasts 2 * 2^SEG_DIV_LOG2 cycles
    parameter int SEG_DIV_LOG2 = 10
) (
    input  logic                         clk200m,
    input  logic                         rst_n,
    input  logic                         disp_we,
    input  logic [io_pkg::seg_width-1:0] disp_wdata,
    output logic                         seg_clk,
    output logic                         seg_clrn,
    output logic                         seg_sout,
    output logic                         seg_en
);

    `include "seg_font.svh"

    localparam int byte_w  = $bits(io_pkg::seg_byte_t);
    localparam int digit_w = io_pkg::seg_width / io_pkg::seg_digits;
    localparam int frame_w = io_pkg::seg_digits * byte_w;
    localparam int bit_w   = $clog2(frame_w);
    localparam int div_w   = SEG_DIV_LOG2 + 1;
    // last cycle of the low half of a bit
    localparam logic [div_w-1:0] half_pt = div_w'((1 << SEG_DIV_LOG2) - 1);

    logic [div_w-1:0]             div_cnt;
    logic                         bit_tick;
    logic                         mid_tick;

    logic                         pend;
    logic [io_pkg::seg_width-1:0] pend_val;
    logic [frame_w-1:0]           frame_bytes;
    logic [frame_w-1:0]           shift_q;
    logic [bit_w-1:0]             bit_cnt;
    logic                         start_frame;

    // free-running divider, never reloaded
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // bit boundary, data changes here with seg_clk low
    assign bit_tick = &div_cnt;
    // middle of the bit, seg_clk rises here
    assign mid_tick = (div_cnt == half_pt);

    // next frame only starts from idle
    assign start_frame = bit_tick && !seg_en && pend;

    // pending value, reset shows 0 once
    // a write racing a frame start stays pending for the next one
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            pend     <= 1'b1;
            pend_val <= '0;
        end else if (disp_we) begin
            pend     <= 1'b1;
            pend_val <= disp_wdata;
        end else if (start_frame) begin
            pend <= 1'b0;
        end
    end

    // digit 7 lands in the top byte so it goes out first
    always_comb begin
        for (int d = 0; d < io_pkg::seg_digits; d++) begin
            frame_bytes[d*byte_w +: byte_w] = seg_font(pend_val[d*digit_w +: digit_w]);
        end
    end

    // shifter, msb leaves first
    always_ff @(posedge clk200m) begin
        if (start_frame) begin
            shift_q <= {frame_bytes[frame_w-2:0], 1'b0};
        end else if (bit_tick && seg_en) begin
            shift_q <= {shift_q[frame_w-2:0], 1'b0};
        end
    end

    // frame control and serial outputs
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            seg_en   <= 1'b0;
            seg_clk  <= 1'b0;
            seg_sout <= 1'b0;
            bit_cnt  <= '0;
        end else if (bit_tick) begin
            seg_clk <= 1'b0;
            if (start_frame) begin
                seg_en   <= 1'b1;
                seg_sout <= frame_bytes[frame_w-1];
                bit_cnt  <= bit_w'(frame_w - 1);
            end else if (seg_en) begin
                if (bit_cnt != '0) begin
                    seg_sout <= shift_q[frame_w-1];
                    bit_cnt  <= bit_cnt - 1'b1;
                end else begin
                    // 64th bit done, idle for at least one bit period
                    seg_en   <= 1'b0;
                    seg_sout <= 1'b0;
                end
            end
        end else if (mid_tick) begin
            // no clock pulses between frames
            seg_clk <= seg_en;
        end
    end

    // shift register clear, released once reset ends
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            seg_clrn <= 1'b0;
        end else begin
            seg_clrn <= 1'b1;
        end
    end

endmodule

//--- design/ps2_kbd/ps2_kbd.sv
// PS/2 keyboard receiver: syncs the lines, assembles and checks frames, queues good scan codes
module ps2_kbd #(
    parameter int FIFO_DEPTH    = 16,
    parameter int FRAME_TIMEOUT = 20000
) (
    input  logic          clk200m,
    input  logic          rst_n,
    input  logic          ps2_clk,
    input  logic          ps2_data,
    input  logic          key_rd,
    output io_pkg::scan_t key_data,
    output logic          key_ready,
    output logic          key_overflow,
    output logic          key_parity_err
);

    localparam int nbits = io_pkg::ps2_frame_bits;
    localparam int cnt_w = $clog2(nbits);
    localparam int wd_w  = $clog2(FRAME_TIMEOUT + 1);
    localparam logic [cnt_w-1:0] last_bit = cnt_w'(nbits - 1);
    localparam logic [wd_w-1:0]  wd_limit = wd_w'(FRAME_TIMEOUT);

    // [1:0] is the two-flop sync, [2] the previous synced value
    logic [2:0]       clk_sync;
    logic [1:0]       data_sync;
    logic             clk_fall;

    logic [nbits-1:0] frame_q;
    logic [nbits-1:0] frame_next;
    logic [cnt_w-1:0] bit_cnt;
    logic [wd_w-1:0]  wd_cnt;

    logic             stop_seen;
    logic             start_ok;
    logic             parity_ok;
    logic             stop_ok;
    logic             frame_ok;

    logic             push;
    io_pkg::scan_t    push_data;
    logic             fifo_full;

    // lines idle high, so sync flops come out of reset at 1
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    // one-cycle strobe on synced high to low
    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    // lsb arrives first, shift right from the top
    assign frame_next = {data_sync[1], frame_q[nbits-1:1]};

    always_ff @(posedge clk200m) begin
        if (clk_fall) begin
            frame_q <= frame_next;
        end
    end

    // frame_next holds the whole frame on the last falling edge
    assign stop_seen = clk_fall && (bit_cnt == last_bit);
    assign start_ok  = ~frame_next[0];
    // data plus parity must hold an odd number of ones
    assign parity_ok = ^frame_next[nbits-2:1];
    assign stop_ok   = frame_next[nbits-1];
    assign frame_ok  = start_ok && parity_ok && stop_ok;

    // push straight from the checking cycle to keep latency short
    assign push      = stop_seen && frame_ok && !fifo_full;
    assign push_data = frame_next[io_pkg::kb_width:1];

    // bit counter and stall watchdog
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            wd_cnt  <= '0;
        end else if (clk_fall) begin
            wd_cnt <= '0;
            if (stop_seen) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else if (bit_cnt != '0 && clk_sync[1]) begin
            // mid-frame with the clock parked high
            if (wd_cnt == wd_limit) begin
                // give up, wait for the next start bit
                bit_cnt <= '0;
                wd_cnt  <= '0;
            end else begin
                wd_cnt <= wd_cnt + 1'b1;
            end
        end else begin
            wd_cnt <= '0;
        end
    end

    // sticky error flags, cleared only by reset
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            key_parity_err <= 1'b0;
            key_overflow   <= 1'b0;
        end else begin
            if (stop_seen && !parity_ok) begin
                key_parity_err <= 1'b1;
            end
            // good frame lost to a full queue
            if (stop_seen && frame_ok && fifo_full) begin
                key_overflow <= 1'b1;
            end
        end
    end

    scan_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_scan_fifo (
        .clk200m   (clk200m),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (key_rd),
        .head      (key_data),
        .not_empty (key_ready),
        .full      (fifo_full)
    );

endmodule

//--- design/ps2_kbd/scan_fifo.sv
// circular queue of keyboard scan codes, head shown combinationally, popped by the host strobe
module scan_fifo #(
    // must be a power of two, at least 2
    parameter int DEPTH = 16
) (
    input  logic          clk200m,
    input  logic          rst_n,
    input  logic          push,
    input  io_pkg::scan_t push_data,
    input  logic          pop,
    output io_pkg::scan_t head,
    output logic          not_empty,
    output logic          full
);

    localparam int addr_w = $clog2(DEPTH);
    localparam logic [addr_w:0] depth_cnt = (addr_w + 1)'(DEPTH);

    io_pkg::scan_t     mem [DEPTH];
    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   count;
    logic              do_push;
    logic              do_pop;

    // pushes into a full queue are dropped, caller raises the flag
    assign do_push = push && !full;
    // pops on an empty queue do nothing
    assign do_pop = pop && not_empty;

    assign full = (count == depth_cnt);
    assign not_empty = (count != '0);

    // oldest entry, moves only when rd_ptr moves
    // or when the slot under rd_ptr gets written into an empty queue
    assign head = mem[rd_ptr];

    // storage
    always_ff @(posedge clk200m) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own since DEPTH is 2^addr_w
    always_ff @(posedge clk200m or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- common/io_pkg.sv
// shared widths, PS/2 frame constants and payload types for the keyboard and display RTL and bench
package io_pkg;

    // one keyboard scan code
    localparam int kb_width = 8;

    // display value, one hex nibble per digit
    localparam int seg_width = 32;
    localparam int seg_digits = 8;

    // start, 8 data lsb first, odd parity, stop
    localparam int ps2_frame_bits = 11;

    // scan code as queued and handed to the host
    typedef logic [kb_width-1:0] scan_t;

    // segment pattern of one digit
    // bit 0 is segment a, bit 6 is g, bit 7 the decimal point
    // active low, so a lit segment reads 0
    typedef logic [7:0] seg_byte_t;

endpackage

//--- design/seg_disp/seg_font.svh
// hex digit to active-low segment byte lookup, included into the display driver's module body
`ifndef SEG_FONT_SVH
`define SEG_FONT_SVH

// decimal point stays dark, so bit 7 is always 1
// lower-case b and d keep them apart from 8 and 0
function automatic io_pkg::seg_byte_t seg_font(input logic [3:0] digit);
    io_pkg::seg_byte_t pattern;
    case (digit)
        4'h0: pattern = 8'hc0;
        4'h1: pattern = 8'hf9;
        4'h2: pattern = 8'ha4;
        4'h3: pattern = 8'hb0;
        4'h4: pattern = 8'h99;
        4'h5: pattern = 8'h92;
        4'h6: pattern = 8'h82;
        4'h7: pattern = 8'hf8;
        4'h8: pattern = 8'h80;
        4'h9: pattern = 8'h90;
        4'ha: pattern = 8'h88;
        4'hb: pattern = 8'h83;
        4'hc: pattern = 8'hc6;
        4'hd: pattern = 8'ha1;
        4'he: pattern = 8'h86;
        4'hf: pattern = 8'h8e;
    endcase
    return pattern;
endfunction

`endif
